/* run_sim.sh */
#!/bin/sh
# build and run the vertex shader testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module vertex_shader_tb -f vertex_shader.f -o vertex_shader_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/vertex_shader_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "all tests passed"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* source/display_pkg.sv */
// display package: visible screen size and the scan counter type
package display_pkg;

	////////////////////
	// scan counters

	// x and y counters from the video timing, wide enough for 800x525
	typedef logic [9:0] pixel_coord_t;

	////////////////////
	// visible area

	localparam int DEFAULT_SCREEN_W = 640;
	localparam int DEFAULT_SCREEN_H = 480;   // first line after the visible area

endpackage

/* source/dot4_unit.sv */
// dot4 unit: sequential four-term q8.8 dot product, one product per cycle
`timescale 1ns/100ps

module dot4_unit import gfx_types_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  i_start,
	input  q8_8_t i_a0, i_a1, i_a2, i_a3,
	input  q8_8_t i_b0, i_b1, i_b2, i_b3,
	output logic  o_done,
	output q8_8_t o_result
);

	q8_8_t op_a [4];
	q8_8_t op_b [4];
	logic running;
	logic [1:0] step;
	logic signed [31:0] acc, prod, sum;

	assign prod = 32'(op_a[step]) * 32'(op_b[step]);   // full q16.16 product
	assign sum  = acc + prod;

	always_ff @(posedge clk) begin
		if (i_start) begin
			op_a <= '{i_a0, i_a1, i_a2, i_a3};
			op_b <= '{i_b0, i_b1, i_b2, i_b3};
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			running  <= 1'b0;
			step     <= 2'd0;
			acc      <= '0;
			o_done   <= 1'b0;
			o_result <= '0;
		end else begin
			o_done <= 1'b0;
			if (i_start) begin
				running <= 1'b1;
				step    <= 2'd0;
				acc     <= '0;
			end else if (running) begin
				acc  <= sum;
				step <= step + 2'd1;
				if (step == 2'd3) begin   // last term
					running  <= 1'b0;
					o_done   <= 1'b1;
					o_result <= sum[23:8];   // back to q8.8, wraps
				end
			end
		end
	end

endmodule

/* source/fixed_divider.sv */
// fixed divider: signed restoring divider, one quotient bit per cycle
`timescale 1ns/100ps

module fixed_divider import gfx_types_pkg::*; #(
	parameter int DIV_WIDTH = DEFAULT_DIV_WIDTH
) (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        i_start,
	input  logic signed [DIV_WIDTH-1:0] i_dividend,
	input  logic signed [DIV_WIDTH-1:0] i_divisor,
	output logic                        o_done,
	output logic signed [DIV_WIDTH-1:0] o_quotient
);

	localparam int CNT_W = $clog2(DIV_WIDTH + 1);

	logic [DIV_WIDTH-1:0] quo, rem, den;   // magnitudes
	logic [DIV_WIDTH:0] rem_shift, diff;
	logic neg_num, neg_quo, den_zero;
	logic [CNT_W-1:0] count;
	logic running, finish;

	assign rem_shift = {rem, quo[DIV_WIDTH-1]};
	assign diff      = rem_shift - {1'b0, den};

	////////////////////
	// magnitude datapath

	always_ff @(posedge clk) begin
		if (i_start) begin
			quo      <= i_dividend[DIV_WIDTH-1] ? -i_dividend : i_dividend;
			den      <= i_divisor[DIV_WIDTH-1] ? -i_divisor : i_divisor;
			rem      <= '0;
			neg_num  <= i_dividend[DIV_WIDTH-1];
			neg_quo  <= i_dividend[DIV_WIDTH-1] ^ i_divisor[DIV_WIDTH-1];
			den_zero <= (i_divisor == '0);
		end else if (running) begin
			if (!diff[DIV_WIDTH]) begin   // divisor fits, keep the difference
				rem <= diff[DIV_WIDTH-1:0];
				quo <= {quo[DIV_WIDTH-2:0], 1'b1};
			end else begin
				rem <= rem_shift[DIV_WIDTH-1:0];
				quo <= {quo[DIV_WIDTH-2:0], 1'b0};
			end
		end
	end

	////////////////////
	// control and sign fix

	always_ff @(posedge clk) begin
		if (reset) begin
			running    <= 1'b0;
			finish     <= 1'b0;
			count      <= '0;
			o_done     <= 1'b0;
			o_quotient <= '0;
		end else begin
			o_done <= 1'b0;
			if (i_start) begin
				running <= 1'b1;
				finish  <= 1'b0;
				count   <= '0;
			end else if (running) begin
				count <= count + 1'b1;
				if (count == CNT_W'(DIV_WIDTH - 1)) begin
					running <= 1'b0;
					finish  <= 1'b1;
				end
			end else if (finish) begin
				finish <= 1'b0;
				o_done <= 1'b1;
				if (den_zero) begin   // saturate toward the dividend's sign
					o_quotient <= neg_num ? {1'b1, {(DIV_WIDTH-1){1'b0}}}
					                      : {1'b0, {(DIV_WIDTH-1){1'b1}}};
				end else begin
					o_quotient <= neg_quo ? -quo : quo;
				end
			end
		end
	end

endmodule

/* source/gfx_types_pkg.sv */
// gfx types: fixed-point, screen and shade types for the vertex datapath
package gfx_types_pkg;

	////////////////////
	// fixed point

	typedef logic signed [15:0] q8_8_t;   // world, matrix, normal, light, clip
	typedef logic signed [15:0] q2_14_t;  // ndc after the divide

	localparam q8_8_t Q8_8_ONE = 16'sh0100;   // w of a world vertex
	localparam int NDC_FRAC_BITS = 14;

	////////////////////
	// screen and shading

	typedef logic [9:0] screen_coord_t;   // pixel position
	typedef logic [2:0] intensity_t;      // 0 dark .. 7 full

	// 0..8 vertex v row r (v major, rows 0,1,3), 9 normal dot light
	typedef logic [3:0] dot_index_t;

	localparam int N_VERTS = 3;

	// width of the shared divider
	localparam int DEFAULT_DIV_WIDTH = 32;

endpackage

/* source/screen_double_buffer.sv */
// screen double buffer: pending result shown on the display at the frame point
`timescale 1ns/100ps

module screen_double_buffer import gfx_types_pkg::*, display_pkg::*; #(
	parameter int SCREEN_H = DEFAULT_SCREEN_H
) (
	input  logic          clk,
	input  logic          reset,
	input  pixel_coord_t  i_pixel_x,
	input  pixel_coord_t  i_pixel_y,
	input  logic          i_result_valid,
	input  screen_coord_t i_x_screen [N_VERTS],
	input  screen_coord_t i_y_screen [N_VERTS],
	input  intensity_t    i_tri_color,
	output screen_coord_t o_x_screen [N_VERTS],
	output screen_coord_t o_y_screen [N_VERTS],
	output intensity_t    o_tri_color
);

	screen_coord_t pend_x [N_VERTS];
	screen_coord_t pend_y [N_VERTS];
	intensity_t pend_color;
	logic frame_point;

	// first pixel of the first line below the visible area
	assign frame_point = (i_pixel_y == pixel_coord_t'(SCREEN_H)) && (i_pixel_x == '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			pend_color  <= '0;
			o_tri_color <= '0;
			for (int v = 0; v < N_VERTS; v++) begin
				pend_x[v]     <= '0;
				pend_y[v]     <= '0;
				o_x_screen[v] <= '0;
				o_y_screen[v] <= '0;
			end
		end else begin
			if (i_result_valid) begin   // newest finished triangle
				pend_x     <= i_x_screen;
				pend_y     <= i_y_screen;
				pend_color <= i_tri_color;
			end
			if (frame_point) begin
				o_x_screen  <= pend_x;
				o_y_screen  <= pend_y;
				o_tri_color <= pend_color;
			end
		end
	end

endmodule

/* source/transform_sequencer.sv */
// transform sequencer: clip transform, perspective divide, viewport and shading
`timescale 1ns/100ps

module transform_sequencer import gfx_types_pkg::*, display_pkg::*; #(
	parameter int SCREEN_W  = DEFAULT_SCREEN_W,
	parameter int SCREEN_H  = DEFAULT_SCREEN_H,
	parameter int DIV_WIDTH = DEFAULT_DIV_WIDTH
) (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        i_start,
	input  logic                        i_dot_done,
	input  q8_8_t                       i_dot_result,
	input  logic                        i_div_done,
	input  logic signed [DIV_WIDTH-1:0] i_div_quotient,
	output logic                        o_busy,
	output logic                        o_dot_start,
	output dot_index_t                  o_dot_index,
	output logic                        o_div_start,
	output logic signed [DIV_WIDTH-1:0] o_dividend,
	output logic signed [DIV_WIDTH-1:0] o_divisor,
	output logic                        o_result_valid,
	output screen_coord_t               o_x_screen [N_VERTS],
	output screen_coord_t               o_y_screen [N_VERTS],
	output intensity_t                  o_tri_color
);

	localparam dot_index_t LAST_CLIP = 4'd8;
	localparam dot_index_t LIGHT_DOT = 4'd9;

	typedef enum logic [2:0] {ST_IDLE, ST_CLIP, ST_DIVIDE, ST_MAP, ST_LIGHT, ST_DONE} state_t;

	state_t state;
	q8_8_t clip_val [3*N_VERTS];   // x, y, w per vertex
	q2_14_t ndc_x [N_VERTS];
	q2_14_t ndc_y [N_VERTS];
	logic [2:0] div_cnt;           // 0..5, x then y per vertex
	logic div_launch;
	logic [1:0] div_vert;
	logic [3:0] num_idx, den_idx;
	logic [15:0] light_mag;
	intensity_t shade;

	// ndc * half + half, in q.14 then back to pixels
	function automatic screen_coord_t viewport(q2_14_t ndc, int half);
		logic signed [31:0] scaled;
		scaled = 32'(ndc) * half + (half <<< NDC_FRAC_BITS);
		return screen_coord_t'(scaled >>> NDC_FRAC_BITS);
	endfunction

	assign div_vert = div_cnt[2:1];
	assign num_idx  = 4'(3 * div_vert) + 4'(div_cnt[0]);
	assign den_idx  = 4'(3 * div_vert) + 4'd2;

	// two-sided shade, |n.l| of 1.0 or more is full
	assign light_mag = i_dot_result[15] ? 16'(-i_dot_result) : 16'(i_dot_result);
	assign shade     = (light_mag >= 16'd256) ? 3'd7 : light_mag[7:5];

	always_ff @(posedge clk) begin
		if (state == ST_CLIP && i_dot_done)
			clip_val[o_dot_index] <= i_dot_result;
		if (state == ST_DIVIDE && !div_launch && i_div_done) begin
			if (div_cnt[0])
				ndc_y[div_vert] <= q2_14_t'(i_div_quotient[15:0]);
			else
				ndc_x[div_vert] <= q2_14_t'(i_div_quotient[15:0]);
		end
	end

	////////////////////
	// control FSM

	always_ff @(posedge clk) begin
		if (reset) begin
			state          <= ST_IDLE;
			o_busy         <= 1'b0;
			o_dot_start    <= 1'b0;
			o_dot_index    <= '0;
			o_div_start    <= 1'b0;
			o_dividend     <= '0;
			o_divisor      <= '0;
			o_result_valid <= 1'b0;
			o_tri_color    <= '0;
			div_cnt        <= '0;
			div_launch     <= 1'b0;
			for (int v = 0; v < N_VERTS; v++) begin
				o_x_screen[v] <= '0;
				o_y_screen[v] <= '0;
			end
		end else begin
			o_dot_start    <= 1'b0;   // single-cycle strobes
			o_div_start    <= 1'b0;
			o_result_valid <= 1'b0;
			case (state)
				ST_IDLE: if (i_start) begin
					o_busy      <= 1'b1;
					o_dot_index <= '0;
					o_dot_start <= 1'b1;
					state       <= ST_CLIP;
				end
				ST_CLIP: if (i_dot_done) begin
					if (o_dot_index == LAST_CLIP) begin
						div_cnt    <= '0;
						div_launch <= 1'b1;
						state      <= ST_DIVIDE;
					end else begin
						o_dot_index <= o_dot_index + 4'd1;
						o_dot_start <= 1'b1;
					end
				end
				ST_DIVIDE: if (div_launch) begin
					o_dividend  <= DIV_WIDTH'(clip_val[num_idx]) <<< NDC_FRAC_BITS;
					o_divisor   <= DIV_WIDTH'(clip_val[den_idx]);
					o_div_start <= 1'b1;
					div_launch  <= 1'b0;
				end else if (i_div_done) begin
					if (div_cnt == 3'd5) begin
						state <= ST_MAP;
					end else begin
						div_cnt    <= div_cnt + 3'd1;
						div_launch <= 1'b1;
					end
				end
				ST_MAP: begin
					for (int v = 0; v < N_VERTS; v++) begin
						o_x_screen[v] <= viewport(ndc_x[v], SCREEN_W / 2);
						o_y_screen[v] <= viewport(ndc_y[v], SCREEN_H / 2);
					end
					o_dot_index <= LIGHT_DOT;
					o_dot_start <= 1'b1;
					state       <= ST_LIGHT;
				end
				ST_LIGHT: if (i_dot_done) begin
					o_tri_color <= shade;
					state       <= ST_DONE;
				end
				ST_DONE: begin
					o_result_valid <= 1'b1;
					o_busy         <= 1'b0;
					state          <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

/* source/triangle_capture.sv */
// triangle capture: holds one triangle and feeds dot4 operands by index
`timescale 1ns/100ps

module triangle_capture import gfx_types_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       i_tri_valid,
	input  q8_8_t      i_vert_x [N_VERTS],
	input  q8_8_t      i_vert_y [N_VERTS],
	input  q8_8_t      i_vert_z [N_VERTS],
	input  q8_8_t      i_norm_x,
	input  q8_8_t      i_norm_y,
	input  q8_8_t      i_norm_z,
	input  q8_8_t      i_light_x,
	input  q8_8_t      i_light_y,
	input  q8_8_t      i_light_z,
	input  q8_8_t      i_vp_row0 [4],
	input  q8_8_t      i_vp_row1 [4],
	input  q8_8_t      i_vp_row3 [4],
	input  logic       i_busy,
	input  dot_index_t i_dot_index,
	output logic       o_start,
	output q8_8_t      o_a0, o_a1, o_a2, o_a3,
	output q8_8_t      o_b0, o_b1, o_b2, o_b3
);

	q8_8_t vert_x [N_VERTS];
	q8_8_t vert_y [N_VERTS];
	q8_8_t vert_z [N_VERTS];
	q8_8_t norm [3];
	q8_8_t light [3];
	q8_8_t row0 [4];
	q8_8_t row1 [4];
	q8_8_t row3 [4];
	q8_8_t row [4];
	logic accept;
	logic [1:0] vert_sel, row_sel;

	// o_start high means the sequencer has not raised busy yet
	assign accept = i_tri_valid && !i_busy && !o_start;

	always_ff @(posedge clk) begin
		if (reset) begin
			o_start <= 1'b0;
		end else begin
			o_start <= accept;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			vert_x <= i_vert_x;
			vert_y <= i_vert_y;
			vert_z <= i_vert_z;
			norm   <= '{i_norm_x, i_norm_y, i_norm_z};
			light  <= '{i_light_x, i_light_y, i_light_z};
			row0   <= i_vp_row0;
			row1   <= i_vp_row1;
			row3   <= i_vp_row3;
		end
	end

	////////////////////
	// operand select

	assign vert_sel = 2'(i_dot_index / 4'd3);
	assign row_sel  = 2'(i_dot_index % 4'd3);

	always_comb begin
		case (row_sel)
			2'd0:    row = row0;
			2'd1:    row = row1;
			default: row = row3;   // z row is not needed
		endcase
	end

	always_comb begin
		{o_a0, o_a1, o_a2, o_a3} = '0;
		{o_b0, o_b1, o_b2, o_b3} = '0;
		if (i_dot_index == 4'd9) begin   // lighting, w terms stay 0
			{o_a0, o_a1, o_a2} = {norm[0], norm[1], norm[2]};
			{o_b0, o_b1, o_b2} = {light[0], light[1], light[2]};
		end else if (i_dot_index < 4'd9) begin
			o_a0 = vert_x[vert_sel];
			o_a1 = vert_y[vert_sel];
			o_a2 = vert_z[vert_sel];
			o_a3 = Q8_8_ONE;
			{o_b0, o_b1, o_b2, o_b3} = {row[0], row[1], row[2], row[3]};
		end
	end

endmodule

/* source/vertex_shader_top.sv */
// vertex shader top: per-triangle transform, divide, viewport and shading
`timescale 1ns/100ps

module vertex_shader_top import gfx_types_pkg::*, display_pkg::*; #(
	parameter int SCREEN_W  = DEFAULT_SCREEN_W,
	parameter int SCREEN_H  = DEFAULT_SCREEN_H,
	parameter int DIV_WIDTH = DEFAULT_DIV_WIDTH
) (
	input  logic          clk,
	input  logic          reset,
	input  pixel_coord_t  i_pixel_x,
	input  pixel_coord_t  i_pixel_y,
	input  logic          i_tri_valid,
	input  q8_8_t         i_vert_x [N_VERTS],
	input  q8_8_t         i_vert_y [N_VERTS],
	input  q8_8_t         i_vert_z [N_VERTS],
	input  q8_8_t         i_norm_x,
	input  q8_8_t         i_norm_y,
	input  q8_8_t         i_norm_z,
	input  q8_8_t         i_light_x,
	input  q8_8_t         i_light_y,
	input  q8_8_t         i_light_z,
	input  q8_8_t         i_vp_row0 [4],
	input  q8_8_t         i_vp_row1 [4],
	input  q8_8_t         i_vp_row3 [4],
	output logic          o_busy,
	output screen_coord_t o_x_screen [N_VERTS],
	output screen_coord_t o_y_screen [N_VERTS],
	output intensity_t    o_tri_color
);

	logic start;
	logic dot_start, dot_done;
	dot_index_t dot_index;
	q8_8_t a0, a1, a2, a3, b0, b1, b2, b3;
	q8_8_t dot_result;
	logic div_start, div_done;
	logic signed [DIV_WIDTH-1:0] dividend, divisor, quotient;
	logic result_valid;
	screen_coord_t x_screen [N_VERTS];
	screen_coord_t y_screen [N_VERTS];
	intensity_t tri_color;

	triangle_capture u_triangle_capture (
		.clk(clk), .reset(reset), .i_tri_valid(i_tri_valid),
		.i_vert_x(i_vert_x), .i_vert_y(i_vert_y), .i_vert_z(i_vert_z),
		.i_norm_x(i_norm_x), .i_norm_y(i_norm_y), .i_norm_z(i_norm_z),
		.i_light_x(i_light_x), .i_light_y(i_light_y), .i_light_z(i_light_z),
		.i_vp_row0(i_vp_row0), .i_vp_row1(i_vp_row1), .i_vp_row3(i_vp_row3),
		.i_busy(o_busy), .i_dot_index(dot_index), .o_start(start),
		.o_a0(a0), .o_a1(a1), .o_a2(a2), .o_a3(a3),
		.o_b0(b0), .o_b1(b1), .o_b2(b2), .o_b3(b3)
	);

	dot4_unit u_dot4_unit (
		.clk(clk), .reset(reset), .i_start(dot_start),
		.i_a0(a0), .i_a1(a1), .i_a2(a2), .i_a3(a3),
		.i_b0(b0), .i_b1(b1), .i_b2(b2), .i_b3(b3),
		.o_done(dot_done), .o_result(dot_result)
	);

	fixed_divider #(.DIV_WIDTH(DIV_WIDTH)) u_fixed_divider (
		.clk(clk), .reset(reset), .i_start(div_start),
		.i_dividend(dividend), .i_divisor(divisor),
		.o_done(div_done), .o_quotient(quotient)
	);

	transform_sequencer #(
		.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H), .DIV_WIDTH(DIV_WIDTH)
	) u_transform_sequencer (
		.clk(clk), .reset(reset), .i_start(start),
		.i_dot_done(dot_done), .i_dot_result(dot_result),
		.i_div_done(div_done), .i_div_quotient(quotient),
		.o_busy(o_busy), .o_dot_start(dot_start), .o_dot_index(dot_index),
		.o_div_start(div_start), .o_dividend(dividend), .o_divisor(divisor),
		.o_result_valid(result_valid), .o_x_screen(x_screen),
		.o_y_screen(y_screen), .o_tri_color(tri_color)
	);

	screen_double_buffer #(.SCREEN_H(SCREEN_H)) u_screen_double_buffer (
		.clk(clk), .reset(reset), .i_pixel_x(i_pixel_x), .i_pixel_y(i_pixel_y),
		.i_result_valid(result_valid), .i_x_screen(x_screen),
		.i_y_screen(y_screen), .i_tri_color(tri_color),
		.o_x_screen(o_x_screen), .o_y_screen(o_y_screen), .o_tri_color(o_tri_color)
	);

endmodule

/* verif/vertex_shader_model.svh */
// vertex shader model: expected screen positions and shade level from the fixed-point rules
`ifndef VERTEX_SHADER_MODEL_SVH
`define VERTEX_SHADER_MODEL_SVH

// sum of four full products, then bits 23..8
function automatic q8_8_t dot4_q8(input q8_8_t a [4], input q8_8_t b [4]);
	int sum;
	sum = 0;
	for (int i = 0; i < 4; i++)
		sum += int'(a[i]) * int'(b[i]);   // wraps like a 32-bit accumulator
	return q8_8_t'(sum >>> 8);
endfunction

// clip / w as q2.14, truncated toward zero
function automatic q2_14_t ndc_divide(input q8_8_t clip, input q8_8_t w);
	int num, quo;
	num = int'(clip) * 16384;
	if (w == 0)
		quo = (num >= 0) ? 32'sh7fffffff : 32'sh80000000;   // saturate on zero w
	else
		quo = num / int'(w);
	return q2_14_t'(quo);
endfunction

function automatic screen_coord_t viewport_map(input q2_14_t ndc, input int half);
	int pix;
	pix = (int'(ndc) * half + half * 16384) >>> 14;
	return screen_coord_t'(pix);   // low 10 bits
endfunction

// two-sided, 1.0 and above is full
function automatic intensity_t shade_level(input q8_8_t n_dot_l);
	int m;
	m = (n_dot_l < 0) ? -int'(n_dot_l) : int'(n_dot_l);
	if (m >= 256)
		return 3'd7;
	else
		return intensity_t'(m / 32);
endfunction

function automatic void project_vertex(input q8_8_t v [4], input q8_8_t r0 [4],
		input q8_8_t r1 [4], input q8_8_t r3 [4],
		output screen_coord_t sx, output screen_coord_t sy);
	q8_8_t cx, cy, cw;
	cx = dot4_q8(v, r0);
	cy = dot4_q8(v, r1);
	cw = dot4_q8(v, r3);
	sx = viewport_map(ndc_divide(cx, cw), DEFAULT_SCREEN_W / 2);
	sy = viewport_map(ndc_divide(cy, cw), DEFAULT_SCREEN_H / 2);
endfunction

`endif

/* verif/vertex_shader_tb.sv */
// vertex shader testbench: triangle table through transform, divide, shading and frame swap
`timescale 1ns/100ps

module vertex_shader_tb import gfx_types_pkg::*, display_pkg::*; ();

	localparam int N_TRI = 6;
	localparam int IGNORED_TRI = 3;   // gets a second strobe while busy
	localparam int WAIT_LIMIT = 2000;

	logic clk, reset;
	pixel_coord_t pixel_x, pixel_y;
	logic tri_valid;
	q8_8_t vert_x [N_VERTS];
	q8_8_t vert_y [N_VERTS];
	q8_8_t vert_z [N_VERTS];
	q8_8_t norm_x, norm_y, norm_z, light_x, light_y, light_z;
	q8_8_t vp_row0 [4];
	q8_8_t vp_row1 [4];
	q8_8_t vp_row3 [4];
	logic busy;
	screen_coord_t x_screen [N_VERTS];
	screen_coord_t y_screen [N_VERTS];
	intensity_t tri_color;

	////////////////////
	// stimulus table, values in q8.8 counts

	int tab_vert [N_TRI][N_VERTS][3];   // x, y, z
	int tab_norm [N_TRI][3];
	int tab_light [N_TRI][3];
	int tab_rows [N_TRI][3][4];   // rows 0, 1, 3
	int tab_exp_x [N_TRI][N_VERTS];
	int tab_exp_y [N_TRI][N_VERTS];
	int tab_exp_color [N_TRI];

	int shown_x [N_VERTS];   // what the display should hold now
	int shown_y [N_VERTS];
	int shown_color;
	int errors, timeouts, checks;
	bit timed_out;
	logic [31:0] rng;

	`include "vertex_shader_model.svh"

	vertex_shader_top u_vertex_shader_top (
		.clk(clk), .reset(reset), .i_pixel_x(pixel_x), .i_pixel_y(pixel_y),
		.i_tri_valid(tri_valid), .i_vert_x(vert_x), .i_vert_y(vert_y), .i_vert_z(vert_z),
		.i_norm_x(norm_x), .i_norm_y(norm_y), .i_norm_z(norm_z),
		.i_light_x(light_x), .i_light_y(light_y), .i_light_z(light_z),
		.i_vp_row0(vp_row0), .i_vp_row1(vp_row1), .i_vp_row3(vp_row3),
		.o_busy(busy), .o_x_screen(x_screen), .o_y_screen(y_screen), .o_tri_color(tri_color)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	task automatic step();
		@(posedge clk);
		#2;   // inputs change just after the edge
	endtask

	task automatic compare(input logic [31:0] got, input logic [31:0] want, input string what);
		checks++;
		if (got !== want) begin
			errors++;
			$display("** Error at %0t ns: %s, got %0d, expected %0d", $time, what, got, want);
		end
	endtask

	task automatic check_display(input string what);
		for (int v = 0; v < N_VERTS; v++) begin
			compare(32'(x_screen[v]), shown_x[v], $sformatf("%s, x of vertex %0d", what, v));
			compare(32'(y_screen[v]), shown_y[v], $sformatf("%s, y of vertex %0d", what, v));
		end
		compare(32'(tri_color), shown_color, $sformatf("%s, color", what));
	endtask

	task automatic wait_busy(input logic level, input int t);
		int n;
		n = 0;
		while (busy !== level && n < WAIT_LIMIT) begin
			step();
			n++;
		end
		if (busy !== level) begin
			$display("timeout: busy never went to %0b for triangle %0d", level, t);
			timeouts++;
			timed_out = 1'b1;
		end
	endtask

	task automatic fill_expected(input int t);
		q8_8_t v4 [4], r0 [4], r1 [4], r3 [4], n4 [4], l4 [4];
		screen_coord_t sx, sy;
		for (int i = 0; i < 4; i++) begin
			r0[i] = q8_8_t'(tab_rows[t][0][i]);
			r1[i] = q8_8_t'(tab_rows[t][1][i]);
			r3[i] = q8_8_t'(tab_rows[t][2][i]);
			n4[i] = (i < 3) ? q8_8_t'(tab_norm[t][i]) : '0;
			l4[i] = (i < 3) ? q8_8_t'(tab_light[t][i]) : '0;
		end
		for (int v = 0; v < N_VERTS; v++) begin
			for (int c = 0; c < 3; c++)
				v4[c] = q8_8_t'(tab_vert[t][v][c]);
			v4[3] = Q8_8_ONE;   // world vertex w
			project_vertex(v4, r0, r1, r3, sx, sy);
			tab_exp_x[t][v] = int'(sx);
			tab_exp_y[t][v] = int'(sy);
		end
		tab_exp_color[t] = int'(shade_level(dot4_q8(n4, l4)));
	endtask

	task automatic load_table();
		int ident [3][4];
		int persp [3][4];
		int lz [4];
		ident = '{'{256, 0, 0, 0}, '{0, 256, 0, 0}, '{0, 0, 0, 256}};
		persp = '{'{256, 0, 0, 0}, '{0, 256, 0, 0}, '{0, 0, 64, 512}};   // w = z/4 + 2
		lz = '{192, 512, -256, -64};   // 0.75, 2.0, -1.0, -0.25
		// identity, corner and center, n.l = +1.0
		tab_vert[0] = '{'{-256, -256, 0}, '{0, 0, 0}, '{128, -128, 0}};
		tab_norm[0] = '{0, 0, 256};
		tab_light[0] = '{0, 0, 256};
		tab_rows[0] = ident;
		tab_exp_x[0] = '{0, 320, 480};
		tab_exp_y[0] = '{0, 240, 120};
		tab_exp_color[0] = 7;
		// identity, far edges, back facing n.l = -0.5
		tab_vert[1] = '{'{256, 256, 0}, '{64, 192, 0}, '{-128, 128, 256}};
		tab_norm[1] = '{0, 0, 256};
		tab_light[1] = '{0, 0, -128};
		tab_rows[1] = ident;
		tab_exp_x[1] = '{640, 400, 160};
		tab_exp_y[1] = '{480, 420, 360};
		tab_exp_color[1] = 4;
		// perspective rows, random vertices within +-2.0
		for (int t = 2; t < N_TRI; t++) begin
			for (int v = 0; v < N_VERTS; v++) begin
				for (int c = 0; c < 3; c++) begin
					rng = xorshift(rng);
					tab_vert[t][v][c] = int'(rng % 32'd1025) - 512;
				end
			end
			tab_norm[t] = '{0, 0, 256};
			tab_light[t] = '{0, 0, lz[t-2]};
			tab_rows[t] = persp;
			fill_expected(t);
		end
	endtask

	task automatic drive_zero_triangle();
		for (int v = 0; v < N_VERTS; v++) begin
			vert_x[v] = '0;
			vert_y[v] = '0;
			vert_z[v] = '0;
		end
		{norm_x, norm_y, norm_z} = '0;
		{light_x, light_y, light_z} = '0;
		for (int i = 0; i < 4; i++) begin
			vp_row0[i] = '0;
			vp_row1[i] = '0;
			vp_row3[i] = '0;
		end
	endtask

	task automatic drive_triangle(input int t);
		for (int v = 0; v < N_VERTS; v++) begin
			vert_x[v] = q8_8_t'(tab_vert[t][v][0]);
			vert_y[v] = q8_8_t'(tab_vert[t][v][1]);
			vert_z[v] = q8_8_t'(tab_vert[t][v][2]);
		end
		norm_x = q8_8_t'(tab_norm[t][0]);
		norm_y = q8_8_t'(tab_norm[t][1]);
		norm_z = q8_8_t'(tab_norm[t][2]);
		light_x = q8_8_t'(tab_light[t][0]);
		light_y = q8_8_t'(tab_light[t][1]);
		light_z = q8_8_t'(tab_light[t][2]);
		for (int i = 0; i < 4; i++) begin
			vp_row0[i] = q8_8_t'(tab_rows[t][0][i]);
			vp_row1[i] = q8_8_t'(tab_rows[t][1][i]);
			vp_row3[i] = q8_8_t'(tab_rows[t][2][i]);
		end
	endtask

	task automatic run_triangle(input int t);
		drive_triangle(t);
		tri_valid = 1'b1;
		step();
		tri_valid = 1'b0;
		wait_busy(1'b1, t);
		if (timed_out)
			return;
		if (t == IGNORED_TRI) begin   // must be dropped while busy
			drive_zero_triangle();
			tri_valid = 1'b1;
			step();
			tri_valid = 1'b0;
		end
		wait_busy(1'b0, t);
		if (timed_out)
			return;
		repeat (3) step();
		compare(32'(busy), 0, $sformatf("triangle %0d busy after finish", t));
		check_display($sformatf("triangle %0d pending", t));
		pixel_y = pixel_coord_t'(DEFAULT_SCREEN_H);
		pixel_x = 10'd1;   // one pixel off the frame point
		step();
		check_display($sformatf("triangle %0d near frame point", t));
		pixel_x = '0;
		step();
		pixel_y = '0;
		for (int v = 0; v < N_VERTS; v++) begin
			shown_x[v] = tab_exp_x[t][v];
			shown_y[v] = tab_exp_y[t][v];
		end
		shown_color = tab_exp_color[t];
		check_display($sformatf("triangle %0d after frame point", t));
	endtask

	////////////////////
	// main sequence

	initial begin
		rng = 32'h240f;
		errors = 0;
		timeouts = 0;
		checks = 0;
		timed_out = 1'b0;
		reset = 1'b1;
		tri_valid = 1'b0;
		pixel_x = '0;
		pixel_y = '0;
		drive_zero_triangle();
		for (int v = 0; v < N_VERTS; v++) begin
			shown_x[v] = 0;
			shown_y[v] = 0;
		end
		shown_color = 0;
		load_table();
		repeat (16) @(posedge clk);
		#2;
		reset = 1'b0;
		compare(32'(busy), 0, "busy after reset");
		check_display("after reset");
		for (int t = 0; t < N_TRI && !timed_out; t++)
			run_triangle(t);
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* vertex_shader.f */
+incdir+verif
source/gfx_types_pkg.sv
source/display_pkg.sv
source/triangle_capture.sv
source/dot4_unit.sv
source/fixed_divider.sv
source/transform_sequencer.sv
source/screen_double_buffer.sv
source/vertex_shader_top.sv
verif/vertex_shader_tb.sv
